//--- flist.f
src/milStdPkg.sv
src/milTxCfgPkg.sv
src/milTxRegs.sv
src/milBitClock.sv
src/milWordQueue.sv
src/milTransmitter.sv
src/milTxTop.sv
sim/milTx_assertions.sv
sim/milTxTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= milTxTb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FLIST ?= flist.f
VFLAGS ?= --binary --assert --timing

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/milTxTb.sv
`default_nettype none

module milTxTb;
	import milStdPkg::*;
	import milTxCfgPkg::*;

	localparam int ClkPeriod = 8;
	localparam int DriveDelay = 1;
	localparam int MaxDiv = 24;
	localparam int NumWords = 11;
	localparam int IdleBits = 80; // Waits between tests, in bit times
	localparam int MaxSamples = 40 * (MaxDiv + 1);
	localparam longint Timeout =
		2 * longint'(NumWords * 20 + IdleBits) * 2 * (MaxDiv + 1) * ClkPeriod + 10000;

	logic clk;
	logic rst;
	logic regWrite;
	CfgAddr regAddr;
	CfgWord regWData;
	CfgWord regRData;
	logic wordPush;
	MilData wordIn;
	logic queueFull;
	logic txOut;
	logic nTxOut;
	logic busy;

	MilData expectQ[$]; // Words expected on the line, in order
	string testName;
	int halfCycles; // Clk cycles per half bit as programmed here
	CfgStatus status;

	milTxTop #(
		.QueueDepthLog2(3)
	) UUT (
		.clk(clk),
		.rst(rst),
		.regWrite(regWrite),
		.regAddr(regAddr),
		.regWData(regWData),
		.regRData(regRData),
		.wordPush(wordPush),
		.wordIn(wordIn),
		.queueFull(queueFull),
		.txOut(txOut),
		.nTxOut(nTxOut),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(Timeout);
		$display("watchdog expired before the tests finished");
		failRun();
	end

	task automatic failRun();
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string what, input logic [31:0] expVal,
			input logic [31:0] actVal);
		$display("mismatch %s %s expected %0h actual %0h", testName, what, expVal, actVal);
		failRun();
	endtask

	task automatic reportProblem(input string what);
		$display("%s: %s", testName, what);
		failRun();
	endtask

	task automatic writeReg(input CfgAddr addr, input CfgWord data);
		@(posedge clk);
		#(DriveDelay);
		regWrite = 1'b1;
		regAddr = addr;
		regWData = data;
		@(posedge clk);
		#(DriveDelay);
		regWrite = 1'b0;
		regAddr = ADDR_STATUS; // Status stays visible between writes
	endtask

	task automatic writeCtrl(input logic grant, input logic queueFlush);
		CfgWord w;
		w = '0;
		w.ctrl.grant = grant;
		w.ctrl.queueFlush = queueFlush;
		writeReg(ADDR_CTRL, w);
	endtask

	task automatic pushWord(input MilWordType wordType, input logic track);
		MilData w;
		w.dataType = wordType;
		w.dataWord = 16'($urandom);
		@(posedge clk);
		#(DriveDelay);
		wordPush = 1'b1;
		wordIn = w;
		@(posedge clk);
		#(DriveDelay);
		wordPush = 1'b0;
		if (track && wordType != WERROR) expectQ.push_back(w);
	endtask

	task automatic readStatus();
		@(negedge clk);
		status = CfgStatus'(regRData);
	endtask

	// Decodes count back-to-back words, then checks the gap after the last
	task automatic decodeBurst(input int count);
		logic samples [0:MaxSamples-1];
		MilData expected;
		logic [15:0] got;
		logic startsHigh;
		logic first;
		logic second;
		logic started;
		int h;
		int base;
		h = halfCycles;
		started = 1'b0;
		while (!started) begin // Skips one-cycle loads of error words
			@(negedge clk);
			if (busy) begin
				@(negedge clk);
				started = busy;
			end
		end
		for (int i = 0; i < count; i++) begin
			for (int c = 0; c < 40 * h; c++) begin
				samples[c] = txOut;
				assert (busy) else reportProblem("busy dropped inside a word");
				@(negedge clk);
			end
			if (expectQ.size() == 0) reportProblem("word on the line that was never pushed");
			expected = expectQ.pop_front();
			startsHigh = (expected.dataType == WCOMMAND) || (expected.dataType == WSTATUS);
			assert (samples[3 * h / 2] == startsHigh)
				else reportMismatch("sync first half", 32'(startsHigh), 32'(samples[3 * h / 2]));
			assert (samples[3 * h - 1 + 3 * h / 2] == !startsHigh)
				else reportMismatch("sync second half", 32'(!startsHigh),
					32'(samples[3 * h - 1 + 3 * h / 2]));
			for (int k = 0; k <= 16; k++) begin
				base = 6 * h - 1 + 2 * h * k + h / 2;
				first = samples[base];
				second = samples[base + h];
				assert (second == !first)
					else reportMismatch("manchester halves", 32'(!first), 32'(second));
				if (k < 16) got[15 - k] = first;
			end
			assert (got == expected.dataWord)
				else reportMismatch("data word", 32'(expected.dataWord), 32'(got));
			assert (first == ~(^expected.dataWord))
				else reportMismatch("odd parity", 32'(~(^expected.dataWord)), 32'(first));
		end
		for (int g = 0; g < 3 * h - 1; g++) begin
			assert (busy && !txOut) else reportProblem("gap not held low while busy");
			@(negedge clk);
		end
		assert (!busy) else reportProblem("busy did not fall after 1.5 bit gap");
	endtask

	task automatic checkQuiet(input int bits);
		for (int c = 0; c < bits * 2 * halfCycles; c++) begin
			@(negedge clk);
			assert (!busy && !txOut) else reportProblem("line activity while none expected");
		end
	endtask

	task automatic expectLevel(input int level);
		readStatus();
		assert (int'(status.queueLevel) == level)
			else reportMismatch("queue level", 32'(level), 32'(status.queueLevel));
	endtask

	initial begin
		void'($urandom(32'h5e0f));
		rst = 1'b1;
		regWrite = 1'b0;
		regAddr = ADDR_STATUS;
		regWData = '0;
		wordPush = 1'b0;
		wordIn = '0;
		halfCycles = MaxDiv + 1;
		repeat (10) @(posedge clk);
		#(DriveDelay);
		rst = 1'b0;

		testName = "wordContent";
		pushWord(WCOMMAND, 1'b1);
		pushWord(WSTATUS, 1'b1);
		pushWord(WDATA, 1'b1);
		pushWord(WCOMMAND, 1'b1);
		writeCtrl(1'b1, 1'b0);
		decodeBurst(4);

		testName = "singleWord";
		pushWord(WDATA, 1'b1);
		decodeBurst(1);
		writeCtrl(1'b0, 1'b0);

		testName = "errorWord";
		pushWord(WERROR, 1'b1);
		pushWord(WDATA, 1'b1);
		writeCtrl(1'b1, 1'b0);
		decodeBurst(1);
		expectLevel(0);
		writeCtrl(1'b0, 1'b0);

		testName = "grantControl";
		pushWord(WSTATUS, 1'b1);
		pushWord(WDATA, 1'b1);
		checkQuiet(4);
		readStatus();
		assert (status.request && !status.busy)
			else reportMismatch("request and busy", 32'h2, {30'd0, status.request, status.busy});
		expectLevel(2);
		writeCtrl(1'b1, 1'b0);
		decodeBurst(2);
		writeCtrl(1'b0, 1'b0);

		testName = "bitRate";
		writeReg(ADDR_DIV, CfgWord'(16'd9));
		halfCycles = 10;
		repeat (4 * (MaxDiv + 1)) @(posedge clk); // Old half bit runs out first
		pushWord(WDATA, 1'b1);
		pushWord(WCOMMAND, 1'b1);
		pushWord(WDATA, 1'b1);
		expectLevel(expectQ.size());
		writeCtrl(1'b1, 1'b0);
		decodeBurst(3);
		expectLevel(expectQ.size());
		writeCtrl(1'b0, 1'b0);

		testName = "fullAndFlush";
		for (int i = 0; i < 8; i++) pushWord(WDATA, 1'b0);
		readStatus();
		assert (queueFull) else reportProblem("queue not full after eight pushes");
		pushWord(WDATA, 1'b0);
		expectLevel(8);
		writeCtrl(1'b0, 1'b1);
		@(posedge clk); // Flush pulse reaches the queue a cycle later
		expectLevel(0);
		assert (!queueFull) else reportProblem("queue still full after flush");
		writeCtrl(1'b1, 1'b0);
		checkQuiet(10);

		if (expectQ.size() == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("%0d words never appeared on the line", expectQ.size());
			failRun();
		end
	end

endmodule

`default_nettype wire

//--- sim/milTx_assertions.sv
`default_nettype none

module milTxAssertions #(
	parameter int QueueDepthLog2 = 3
) (
	input logic clk,
	input logic rst,
	input logic grant,
	input logic txOut,
	input logic nTxOut,
	input logic busy,
	input logic queueFull,
	input logic [QueueDepthLog2:0] queueLevel
);

	// Line pair is complementary only while granted
	property linePairGranted;
		@(posedge clk) disable iff (rst) grant |-> (nTxOut == !txOut);
	endproperty

	property linesLowUngranted;
		@(posedge clk) disable iff (rst) !grant |-> (!txOut && !nTxOut);
	endproperty

	property fullBlocksGrowth;
		@(posedge clk) disable iff (rst) queueFull |=> (queueLevel <= $past(queueLevel));
	endproperty

	// nTxOut idles high when granted, so only txOut is checked here
	property busyFallsLow;
		@(posedge clk) disable iff (rst) $fell(busy) |-> !txOut;
	endproperty

	assert property (linePairGranted) else $error("line pair not complementary");
	assert property (linesLowUngranted) else $error("lines driven without grant");
	assert property (fullBlocksGrowth) else $error("queue level grew while full");
	assert property (busyFallsLow) else $error("busy fell with the line high");

endmodule

bind milTxTop milTxAssertions #(
	.QueueDepthLog2(QueueDepthLog2)
) lineChecks (
	.clk(clk),
	.rst(rst),
	.grant(grant),
	.txOut(txOut),
	.nTxOut(nTxOut),
	.busy(busy),
	.queueFull(queueFull),
	.queueLevel(queueLevel)
);

`default_nettype wire

//--- src/milTxTop.sv
`default_nettype none

module milTxTop #(
	parameter int QueueDepthLog2 = 3,
	parameter int DivReset = 24
) (
	input logic clk,
	input logic rst,
	input logic regWrite,
	input milTxCfgPkg::CfgAddr regAddr,
	input milTxCfgPkg::CfgWord regWData,
	output milTxCfgPkg::CfgWord regRData,
	input logic wordPush,
	input milStdPkg::MilData wordIn,
	output logic queueFull,
	output logic txOut,
	output logic nTxOut,
	output logic busy
);
	import milStdPkg::*;

	logic grant;
	logic flush;
	logic request;
	logic [15:0] halfBitDiv;
	logic upStrobe;
	logic downStrobe;
	logic pushRequest;
	logic pushDone;
	logic [QueueDepthLog2:0] queueLevel;
	MilData pushData;

	milTxRegs #(
		.QueueDepthLog2(QueueDepthLog2),
		.DivReset(DivReset)
	) regs (
		.clk(clk),
		.rst(rst),
		.regWrite(regWrite),
		.regAddr(regAddr),
		.regWData(regWData),
		.regRData(regRData),
		.busy(busy),
		.request(request),
		.queueLevel(queueLevel),
		.grant(grant),
		.flush(flush),
		.halfBitDiv(halfBitDiv)
	);

	milBitClock bitClock (
		.clk(clk),
		.rst(rst),
		.halfBitDiv(halfBitDiv),
		.upStrobe(upStrobe),
		.downStrobe(downStrobe)
	);

	milWordQueue #(
		.QueueDepthLog2(QueueDepthLog2)
	) queue (
		.clk(clk),
		.rst(rst),
		.wordPush(wordPush),
		.wordIn(wordIn),
		.flush(flush),
		.pushDone(pushDone),
		.pushRequest(pushRequest),
		.pushData(pushData),
		.queueFull(queueFull),
		.queueLevel(queueLevel)
	);

	milTransmitter transmitter (
		.clk(clk),
		.rst(rst),
		.upStrobe(upStrobe),
		.downStrobe(downStrobe),
		.grant(grant),
		.pushRequest(pushRequest),
		.pushData(pushData),
		.pushDone(pushDone),
		.busy(busy),
		.request(request),
		.txOut(txOut),
		.nTxOut(nTxOut)
	);

endmodule

`default_nettype wire

//--- src/milTransmitter.sv
`default_nettype none

module milTransmitter (
	input logic clk,
	input logic rst,
	input logic upStrobe,
	input logic downStrobe,
	input logic grant,
	input logic pushRequest,
	input milStdPkg::MilData pushData,
	output logic pushDone,
	output logic busy,
	output logic request,
	output logic txOut,
	output logic nTxOut
);
	import milStdPkg::*;

	// Sync half-states: L0x/H1x for data sync, H0x/L1x for command and status
	typedef enum logic [3:0] {
		IDLE,
		LOAD,
		DATA,
		PARITY,
		GAP1,
		GAP2,
		L01,
		L02,
		H11,
		H12,
		H01,
		H02,
		L11,
		L12
	} TxState;

	TxState state;
	TxState nextState;
	MilData curWord;
	logic line;
	logic parity;
	logic [3:0] bitIndex;
	logic [3:0] nextIndex;

	assign txOut = grant ? line : 1'b0;
	assign nTxOut = grant ? !line : 1'b0;

	assign busy = (state != IDLE);
	assign pushDone = (state == LOAD);
	assign request = pushRequest || busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextIndex = (state == DATA) ? bitIndex - 4'd1 : 4'd15; // MSB first
		nextState = state;
		case (state)
			IDLE: if (pushRequest && upStrobe && grant) nextState = LOAD;
			LOAD: begin
				if (curWord.dataType == WERROR) begin
					nextState = IDLE; // Dropped silently
				end else if (syncStartsHigh(curWord.dataType)) begin
					nextState = H01;
				end else begin
					nextState = L01;
				end
			end
			L01: if (downStrobe) nextState = L02;
			L02: if (downStrobe) nextState = H11;
			H11: if (upStrobe) nextState = H12;
			H12: if (upStrobe) nextState = DATA;
			H01: if (downStrobe) nextState = H02;
			H02: if (downStrobe) nextState = L11;
			L11: if (upStrobe) nextState = L12;
			L12: if (upStrobe) nextState = DATA;
			DATA: if (upStrobe && nextIndex == 4'd15) nextState = PARITY;
			PARITY: if (upStrobe) nextState = pushRequest ? LOAD : GAP1;
			GAP1: if (upStrobe) nextState = GAP2;
			GAP2: if (downStrobe) nextState = IDLE;
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			line <= 1'b0;
			bitIndex <= 4'd15;
		end else begin
			if (upStrobe) begin
				bitIndex <= nextIndex;
			end
			case (nextState)
				H01, H02, H11, H12: line <= 1'b1;
				DATA: begin
					if (upStrobe) line <= curWord.dataWord[nextIndex];
					if (downStrobe) line <= !curWord.dataWord[bitIndex];
				end
				PARITY: begin
					if (upStrobe) line <= parity;
					if (downStrobe) line <= !parity;
				end
				LOAD: line <= line; // Holds for the single load cycle
				default: line <= 1'b0;
			endcase
		end
	end

	// Odd parity over the 16 data bits
	always_ff @(posedge clk) begin
		if (nextState == LOAD) begin
			curWord <= pushData;
			parity <= 1'b1;
		end else if (nextState == DATA && upStrobe) begin
			parity <= parity ^ curWord.dataWord[nextIndex];
		end
	end

endmodule

`default_nettype wire

//--- src/milWordQueue.sv
`default_nettype none

module milWordQueue #(
	parameter int QueueDepthLog2 = 3
) (
	input logic clk,
	input logic rst,
	input logic wordPush,
	input milStdPkg::MilData wordIn,
	input logic flush,
	input logic pushDone,
	output logic pushRequest,
	output milStdPkg::MilData pushData,
	output logic queueFull,
	output logic [QueueDepthLog2:0] queueLevel
);
	import milStdPkg::*;

	localparam int Depth = 1 << QueueDepthLog2;

	MilData mem [Depth];
	logic [QueueDepthLog2-1:0] wrPtr;
	logic [QueueDepthLog2-1:0] rdPtr;
	logic doPush;
	logic doPop;

	assign queueFull = (queueLevel == (QueueDepthLog2 + 1)'(Depth));
	assign pushRequest = (queueLevel != '0);
	assign pushData = mem[rdPtr];

	assign doPush = wordPush && !queueFull; // Dropped when full
	assign doPop = pushDone && pushRequest;

	always_ff @(posedge clk) begin
		if (doPush) begin
			mem[wrPtr] <= wordIn;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
			queueLevel <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			if (doPush && !doPop) begin
				queueLevel <= queueLevel + 1'b1;
			end else if (doPop && !doPush) begin
				queueLevel <= queueLevel - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/milBitClock.sv
`default_nettype none

module milBitClock (
	input logic clk,
	input logic rst,
	input logic [15:0] halfBitDiv,
	output logic upStrobe,
	output logic downStrobe
);

	logic [15:0] count;
	logic phase; // Level of the bus bit clock

	// Divider value is picked up only at a half-bit boundary
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
			phase <= 1'b0;
			upStrobe <= 1'b0;
			downStrobe <= 1'b0;
		end else begin
			upStrobe <= 1'b0;
			downStrobe <= 1'b0;
			if (count == 16'd0) begin
				count <= halfBitDiv;
				phase <= !phase;
				upStrobe <= !phase; // Rising half, start of bit
				downStrobe <= phase; // Falling half, mid bit
			end else begin
				count <= count - 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/milTxRegs.sv
`default_nettype none

module milTxRegs #(
	parameter int QueueDepthLog2 = 3,
	parameter int DivReset = 24
) (
	input logic clk,
	input logic rst,
	input logic regWrite,
	input milTxCfgPkg::CfgAddr regAddr,
	input milTxCfgPkg::CfgWord regWData,
	output milTxCfgPkg::CfgWord regRData,
	input logic busy,
	input logic request,
	input logic [QueueDepthLog2:0] queueLevel,
	output logic grant,
	output logic flush,
	output logic [15:0] halfBitDiv
);
	import milTxCfgPkg::*;

	CfgStatus status;

	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= 1'b0;
			flush <= 1'b0;
			halfBitDiv <= 16'(DivReset);
		end else begin
			flush <= 1'b0; // Pulse only
			if (regWrite) begin
				case (regAddr)
					ADDR_CTRL: begin
						grant <= regWData.ctrl.grant;
						flush <= regWData.ctrl.queueFlush;
					end
					ADDR_DIV: begin
						halfBitDiv <= regWData.div.halfBitDiv;
					end
					default: begin
					end
				endcase
			end
		end
	end

	always_comb begin
		status = '0;
		status.busy = busy;
		status.request = request;
		status.queueLevel = 8'(queueLevel);
	end

	// Status readback only, other addresses read zero
	always_comb begin
		regRData = '0;
		if (regAddr == ADDR_STATUS) begin
			regRData = CfgWord'(status);
		end
	end

endmodule

`default_nettype wire

//--- src/milTxCfgPkg.sv
`default_nettype none

package milTxCfgPkg;

	typedef enum logic [1:0] {
		ADDR_CTRL,
		ADDR_DIV,
		ADDR_STATUS
	} CfgAddr;

	typedef struct packed {
		logic grant;
		logic queueFlush; // Self-clearing
		logic [13:0] reserved;
	} CfgCtrl;

	typedef struct packed {
		logic [15:0] halfBitDiv; // Clk cycles per half bit, minus one
	} CfgDiv;

	// Same data word, decoded by address
	typedef union packed {
		CfgCtrl ctrl;
		CfgDiv div;
	} CfgWord;

	typedef struct packed {
		logic busy;
		logic request;
		logic [7:0] queueLevel;
		logic [5:0] reserved;
	} CfgStatus;

endpackage

`default_nettype wire

//--- src/milStdPkg.sv
`default_nettype none

package milStdPkg;

	// Kind of word carried on the bus
	typedef enum logic [1:0] {
		WERROR,
		WDATA,
		WCOMMAND,
		WSTATUS
	} MilWordType;

	// One queued word with its type tag
	typedef struct packed {
		MilWordType dataType;
		logic [15:0] dataWord;
	} MilData;

	// Command and status syncs go high first, data syncs go low first
	function automatic logic syncStartsHigh(input MilWordType wordType);
		logic result;
		case (wordType)
			WCOMMAND: result = 1'b1;
			WSTATUS: result = 1'b1;
			default: result = 1'b0;
		endcase
		return result;
	endfunction

endpackage

`default_nettype wire
